//--- src/emu_pkg.sv
package emu_pkg;

    // instruction memory of the target, one 16-bit instruction per word.
    localparam int imem_depth = 16;

    typedef enum logic [3:0] {
        addr_ctrl        = 4'd0,
        addr_status      = 4'd1,
        addr_imem        = 4'd2,
        addr_trace       = 4'd3,
        addr_trace_count = 4'd4
    } reg_addr_e;

    typedef struct packed {
        logic        write;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } host_resp_t;

    // one register-file write of the target.
    typedef struct packed {
        logic [1:0]  waddr;
        logic [15:0] wdata;
    } trace_rec_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_stall = 2'd2
    } run_state_e;

    typedef enum logic [1:0] {
        cmd_run          = 2'd0,
        cmd_halt         = 2'd1,
        cmd_reset_target = 2'd2
    } emu_cmd_e;

    // instruction word is op[15:14], rd[13:12], rs[11:10], imm[7:0].
    typedef enum logic [1:0] {
        op_li  = 2'd0,
        op_add = 2'd1,
        op_sub = 2'd2,
        op_xor = 2'd3
    } cpu_op_e;

endpackage

//--- src/ctrl_bridge.sv
`timescale 1ns/1ps

module ctrl_bridge #(
    parameter int trace_depth = 8
) (
    input  logic                         emu_ref,
    input  logic                         reset,

    input  emu_pkg::host_req_t           req,
    input  logic                         req_valid,
    output logic                         req_ready,
    output emu_pkg::host_resp_t          resp,
    output logic                         resp_valid,
    input  logic                         resp_ready,

    output logic                         cmd_valid,
    output emu_pkg::emu_cmd_e            cmd,
    output logic [15:0]                  step_count,

    output logic                         imem_wen,
    output logic [3:0]                   imem_addr,
    output logic [15:0]                  imem_data,

    output logic                         pop,
    input  emu_pkg::trace_rec_t          head,
    input  logic                         empty,
    input  logic [$clog2(trace_depth):0] count,

    input  emu_pkg::run_state_e          state,
    input  logic [15:0]                  steps_left
);

    logic              accept;
    emu_pkg::reg_addr_e addr;
    logic [31:0]       rd_data;
    logic              rd_err;

    // only one access may be outstanding.
    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign addr      = emu_pkg::reg_addr_e'(req.addr);

    // the head is captured into the response on the same edge that advances the FIFO.
    assign pop = accept && !req.write && addr == emu_pkg::addr_trace && !empty;

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (addr)
            emu_pkg::addr_ctrl, emu_pkg::addr_imem: begin
                rd_data = '0;
            end
            emu_pkg::addr_status: begin
                rd_err  = req.write;
                rd_data = {14'd0, state, steps_left};
            end
            emu_pkg::addr_trace: begin
                rd_err = req.write;
                if (!empty) begin
                    rd_data = {1'b1, 13'd0, head};
                end
            end
            emu_pkg::addr_trace_count: begin
                rd_err  = req.write;
                rd_data = 32'(count);
            end
            default: begin
                rd_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge emu_ref) begin
        if (reset) begin
            resp_valid <= 1'b0;
            cmd_valid  <= 1'b0;
            imem_wen   <= 1'b0;
        end else begin
            if (accept) begin
                resp_valid <= 1'b1;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
            cmd_valid <= accept && req.write && addr == emu_pkg::addr_ctrl;
            imem_wen  <= accept && req.write && addr == emu_pkg::addr_imem;
        end
    end

    always_ff @(posedge emu_ref) begin
        if (accept) begin
            // writes and errors always carry zero data.
            resp.rdata <= (req.write || rd_err) ? 32'd0 : rd_data;
            resp.err   <= rd_err;
            cmd        <= emu_pkg::emu_cmd_e'(req.wdata[31:30]);
            step_count <= req.wdata[15:0];
            imem_addr  <= req.wdata[19:16];
            imem_data  <= req.wdata[15:0];
        end
    end

endmodule

//--- src/run_ctrl.sv
`timescale 1ns/1ps

module run_ctrl (
    input  logic                emu_ref,
    input  logic                reset,
    input  logic                cmd_valid,
    input  emu_pkg::emu_cmd_e   cmd,
    input  logic [15:0]         step_count,
    input  logic                trace_full,
    output logic                step_en,
    output logic                target_clear,
    output emu_pkg::run_state_e state,
    output logic [15:0]         steps_left
);

    assign step_en = state == emu_pkg::st_run && steps_left != 16'd0 && !trace_full;

    always_ff @(posedge emu_ref) begin
        if (reset) begin
            state        <= emu_pkg::st_idle;
            steps_left   <= 16'd0;
            target_clear <= 1'b0;
        end else begin
            target_clear <= cmd_valid && cmd == emu_pkg::cmd_reset_target;
            if (cmd_valid) begin
                case (cmd)
                    emu_pkg::cmd_run: begin
                        steps_left <= step_count;
                        if (step_count == 16'd0) begin
                            state <= emu_pkg::st_idle;
                        end else begin
                            state <= emu_pkg::st_run;
                        end
                    end
                    emu_pkg::cmd_halt, emu_pkg::cmd_reset_target: begin
                        steps_left <= 16'd0;
                        state      <= emu_pkg::st_idle;
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end else begin
                case (state)
                    emu_pkg::st_run: begin
                        if (trace_full) begin
                            state <= emu_pkg::st_stall;
                        end else if (step_en) begin
                            steps_left <= steps_left - 16'd1;
                            if (steps_left == 16'd1) begin
                                state <= emu_pkg::st_idle;
                            end
                        end
                    end
                    // resume as soon as the host has made room.
                    emu_pkg::st_stall: begin
                        if (!trace_full) begin
                            state <= emu_pkg::st_run;
                        end
                    end
                    default: begin
                        state <= emu_pkg::st_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- src/target_cpu.sv
`timescale 1ns/1ps

module target_cpu (
    input  logic                emu_ref,
    input  logic                reset,
    input  logic                step_en,
    input  logic                target_clear,
    input  logic                imem_wen,
    input  logic [3:0]          imem_addr,
    input  logic [15:0]         imem_data,
    output logic                rec_valid,
    output emu_pkg::trace_rec_t rec
);

    localparam int pc_w = $clog2(emu_pkg::imem_depth);

    logic [15:0]      imem [emu_pkg::imem_depth];
    logic [15:0]      regs [4];
    logic [pc_w-1:0]  pc;
    logic [15:0]      instr;
    emu_pkg::cpu_op_e op;
    logic [1:0]       rd;
    logic [1:0]       rs;
    logic [7:0]       imm;
    logic [15:0]      result;

    // the program survives a target reset, so the memory only follows host writes.
    always_ff @(posedge emu_ref) begin
        if (imem_wen) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign instr = imem[pc];
    assign op    = emu_pkg::cpu_op_e'(instr[15:14]);
    assign rd    = instr[13:12];
    assign rs    = instr[11:10];
    assign imm   = instr[7:0];

    always_comb begin
        case (op)
            emu_pkg::op_li:  result = {8'd0, imm};
            emu_pkg::op_add: result = regs[rd] + regs[rs];
            emu_pkg::op_sub: result = regs[rd] - regs[rs];
            emu_pkg::op_xor: result = regs[rd] ^ regs[rs];
            default:         result = 16'd0;
        endcase
    end

    always_ff @(posedge emu_ref) begin
        if (reset || target_clear) begin
            pc        <= '0;
            rec_valid <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= 16'd0;
            end
        end else begin
            rec_valid <= step_en;
            if (step_en) begin
                regs[rd] <= result;
                // pc wraps at the end of the memory.
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge emu_ref) begin
        if (step_en) begin
            rec.waddr <= rd;
            rec.wdata <= result;
        end
    end

endmodule

//--- src/trace_buffer.sv
`timescale 1ns/1ps

module trace_buffer #(
    parameter int trace_depth = 8
) (
    input  logic                         emu_ref,
    input  logic                         reset,
    input  logic                         target_clear,
    input  logic                         rec_valid,
    input  emu_pkg::trace_rec_t          rec,
    input  logic                         pop,
    output emu_pkg::trace_rec_t          head,
    output logic                         empty,
    output logic                         trace_full,
    output logic [$clog2(trace_depth):0] count
);

    localparam int ptr_w = $clog2(trace_depth);
    localparam logic [ptr_w:0] full_level = (ptr_w + 1)'(trace_depth - 1);

    emu_pkg::trace_rec_t mem [trace_depth];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic                rd_en;
    logic [ptr_w:0]      fill;

    assign rd_en = pop && !empty;
    assign empty = count == '0;
    assign head  = mem[rd_ptr];

    // the record landing this cycle is counted too, so the step granted
    // in the same cycle still finds a free slot.
    assign fill       = count + (ptr_w + 1)'(rec_valid);
    assign trace_full = fill >= full_level;

    always_ff @(posedge emu_ref) begin
        if (rec_valid) begin
            mem[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge emu_ref) begin
        if (reset || target_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rec_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rec_valid && !rd_en) begin
                count <= count + 1'b1;
            end else if (!rec_valid && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/emu_system.sv
`timescale 1ns/1ps

module emu_system #(
    parameter int trace_depth = 8
) (
    input  logic                emu_ref,
    input  logic                reset,
    input  emu_pkg::host_req_t  req,
    input  logic                req_valid,
    output logic                req_ready,
    output emu_pkg::host_resp_t resp,
    output logic                resp_valid,
    input  logic                resp_ready
);

    logic                         cmd_valid;
    emu_pkg::emu_cmd_e            cmd;
    logic [15:0]                  step_count;
    logic                         imem_wen;
    logic [3:0]                   imem_addr;
    logic [15:0]                  imem_data;
    logic                         pop;
    emu_pkg::trace_rec_t          head;
    logic                         empty;
    logic                         trace_full;
    logic [$clog2(trace_depth):0] count;
    emu_pkg::run_state_e          state;
    logic [15:0]                  steps_left;
    logic                         step_en;
    logic                         target_clear;
    logic                         rec_valid;
    emu_pkg::trace_rec_t          rec;

    ctrl_bridge #(
        .trace_depth (trace_depth)
    ) u_bridge (
        .emu_ref    (emu_ref),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .step_count (step_count),
        .imem_wen   (imem_wen),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .count      (count),
        .state      (state),
        .steps_left (steps_left)
    );

    run_ctrl u_run_ctrl (
        .emu_ref      (emu_ref),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .step_count   (step_count),
        .trace_full   (trace_full),
        .step_en      (step_en),
        .target_clear (target_clear),
        .state        (state),
        .steps_left   (steps_left)
    );

    target_cpu u_cpu (
        .emu_ref      (emu_ref),
        .reset        (reset),
        .step_en      (step_en),
        .target_clear (target_clear),
        .imem_wen     (imem_wen),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .rec_valid    (rec_valid),
        .rec          (rec)
    );

    trace_buffer #(
        .trace_depth (trace_depth)
    ) u_trace (
        .emu_ref      (emu_ref),
        .reset        (reset),
        .target_clear (target_clear),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .pop          (pop),
        .head         (head),
        .empty        (empty),
        .trace_full   (trace_full),
        .count        (count)
    );

endmodule

//--- tests/tb_emu_system.sv
`timescale 1ns/1ps

module tb_emu_system;

    logic                emu_ref;
    logic                reset;
    emu_pkg::host_req_t  req;
    logic                req_valid;
    logic                req_ready;
    emu_pkg::host_resp_t resp;
    logic                resp_valid;
    logic                resp_ready;

    int checks;
    int errors;
    int test_errors;
    int cur_test;
    bit stopped;

    emu_system #(
        .trace_depth (8)
    ) uut (
        .emu_ref    (emu_ref),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        emu_ref = 1'b0;
        forever #50 emu_ref = ~emu_ref;
    end

    task automatic report_problem(input string what);
        errors++;
        test_errors++;
        $display("t=%0t %s", $time, what);
    endtask

    task automatic check_resp(input emu_pkg::host_resp_t exp, input emu_pkg::host_resp_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR t=%0t resp expected rdata=%h err=%b actual rdata=%h err=%b",
                     $time, exp.rdata, exp.err, got.rdata, got.err);
        end
    endtask

    task automatic check_rec(input emu_pkg::trace_rec_t exp, input emu_pkg::trace_rec_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR t=%0t rec expected waddr=%0d wdata=%h actual waddr=%0d wdata=%h",
                     $time, exp.waddr, exp.wdata, got.waddr, got.wdata);
        end
    endtask

    // one complete access; the response is held for a random number of cycles.
    task automatic bus_access(input emu_pkg::host_req_t r, output emu_pkg::host_resp_t got);
        int n;
        int hold;
        got = '0;
        if (stopped) return;
        @(posedge emu_ref);
        req       <= r;
        req_valid <= 1'b1;
        n = 0;
        @(negedge emu_ref);
        while (!req_ready && n < 50) begin
            @(negedge emu_ref);
            n++;
        end
        if (!req_ready) begin
            report_problem("the request was never accepted");
            stopped = 1'b1;
            return;
        end
        @(posedge emu_ref);
        req_valid <= 1'b0;
        n = 0;
        @(negedge emu_ref);
        while (!resp_valid && n < 50) begin
            @(negedge emu_ref);
            n++;
        end
        if (!resp_valid) begin
            report_problem("no response arrived after the request was accepted");
            stopped = 1'b1;
            return;
        end
        if (n != 0) report_problem("the response came later than one cycle after acceptance");
        got  = resp;
        hold = int'($urandom % 4);
        repeat (hold) begin
            @(negedge emu_ref);
            if (!resp_valid || resp !== got) begin
                report_problem("the response changed while resp_ready was low");
            end
        end
        @(posedge emu_ref);
        resp_ready <= 1'b1;
        @(negedge emu_ref);
        if (!resp_valid || resp !== got) begin
            report_problem("the response was gone before resp_ready was seen");
        end
        @(posedge emu_ref);
        resp_ready <= 1'b0;
        @(negedge emu_ref);
        if (resp_valid || !req_ready) begin
            report_problem("the response was still pending a cycle after it was accepted");
        end
    endtask

    task automatic replay_line(input string op, input logic [3:0] addr,
                               input logic [31:0] data, input logic err);
        emu_pkg::host_req_t  r;
        emu_pkg::host_resp_t got;
        emu_pkg::host_resp_t exp;
        emu_pkg::host_resp_t hdr;
        int                  polls;
        r.write   = (op == "W");
        r.addr    = addr;
        r.wdata   = (op == "W") ? data : 32'd0;
        exp.rdata = (op == "W") ? 32'd0 : data;
        exp.err   = err;
        bus_access(r, got);
        if (op == "P") begin
            polls = 0;
            while (!stopped && got.rdata !== data && polls < 200) begin
                bus_access(r, got);
                polls++;
            end
        end
        if (stopped) return;
        if (op == "P" && got.rdata !== data) begin
            report_problem($sformatf("register %0d never reached %h", addr, data));
        end else if (op == "T") begin
            // a record read carries the valid flag in bit 31 and zeros above the record.
            exp.rdata       = {1'b1, 31'd0};
            hdr             = got;
            hdr.rdata[17:0] = '0;
            check_resp(exp, hdr);
            check_rec(emu_pkg::trace_rec_t'(data[17:0]),
                      emu_pkg::trace_rec_t'(got.rdata[17:0]));
        end else begin
            check_resp(exp, got);
        end
    endtask

    task automatic close_test;
        if (cur_test != 0) begin
            if (test_errors == 0) $display("test %0d done, no errors", cur_test);
            else $display("test %0d done, %0d errors", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          code;
        int          id;
        string       op;
        string       skip;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] err;
        req         = '0;
        req_valid   = 1'b0;
        resp_ready  = 1'b0;
        reset       = 1'b1;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        cur_test    = 0;
        stopped     = 1'b0;
        void'($urandom(32'hb4c68d89));
        repeat (16) @(posedge emu_ref);
        reset <= 1'b0;
        fd = $fopen("tests/emu_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("the test data file could not be opened");
            stopped = 1'b1;
        end
        while (!stopped) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) break;
            if (op == "#") begin
                code = $fgets(skip, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %d", addr, data, err, id);
            if (code != 4) begin
                report_problem("a line of the test data file is malformed");
                break;
            end
            if (id != cur_test) begin
                close_test();
                cur_test = id;
            end
            replay_line(op, addr[3:0], data, err[0]);
        end
        close_test();
        if (fd != 0) $fclose(fd);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0 && !stopped) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/emu_pkg.sv
src/ctrl_bridge.sv
src/run_ctrl.sv
src/target_cpu.sv
src/trace_buffer.sv
src/emu_system.sv
tests/tb_emu_system.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_emu_system -o tb_emu_system

# the simulation reads its data file relative to the project root.
out=$(./obj_dir/tb_emu_system)
echo "$out"

if grep -q "TEST PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- tests/emu_testdata.txt
# op addr data err test : W writes data, R and P expect data (P polls until equal)
# T expects a trace record {waddr, wdata} in data; err is the expected error bit
R 1 00000000 0 1
R 4 00000000 0 1
W 2 00000005 0 2
W 2 00011003 0 2
W 2 00024400 0 2
W 2 00039000 0 2
W 2 0004E400 0 2
W 2 00053080 0 2
W 2 00067C00 0 2
W 2 0007AC00 0 2
W 2 0008C800 0 2
W 2 00095000 0 2
W 2 000A20FF 0 2
W 2 000B6400 0 2
W 2 000C8C00 0 2
W 2 000DF000 0 2
W 2 000E5800 0 2
W 2 000F0001 0 2
W 0 00000005 0 2
P 1 00000000 0 2
T 3 00005 0 2
T 3 10003 0 2
T 3 00008 0 2
T 3 1FFFB 0 2
T 3 2FFFB 0 2
R 3 00000000 0 2
W 0 00000014 0 3
P 1 0002000D 0 3
R 4 00000007 0 3
T 3 30080 0 3
T 3 30100 0 3
T 3 2FEFB 0 3
T 3 0FEF3 0 3
T 3 1FEEE 0 3
T 3 200FF 0 3
T 3 2FFED 0 3
T 3 0FDF3 0 3
T 3 3FCF3 0 3
T 3 1FEDB 0 3
T 3 00001 0 3
T 3 00005 0 3
T 3 10003 0 3
T 3 00008 0 3
T 3 1FFFB 0 3
T 3 20016 0 3
T 3 30080 0 3
T 3 30100 0 3
T 3 2FF16 0 3
T 3 0FF1E 0 3
P 1 00000000 0 3
W 0 00000014 0 4
P 1 0002000D 0 4
W 0 40000000 0 4
R 1 00000000 0 4
W 0 00000002 0 4
T 3 1FF19 0 4
T 3 200FF 0 4
T 3 20018 0 4
T 3 0FE1E 0 4
T 3 3FF1E 0 4
T 3 1FF31 0 4
T 3 00001 0 4
P 1 00000000 0 4
R 4 00000002 0 4
T 3 00005 0 4
W 0 80000000 0 5
R 4 00000000 0 5
W 0 00000005 0 5
P 1 00000000 0 5
T 3 00005 0 5
T 3 10003 0 5
T 3 00008 0 5
T 3 1FFFB 0 5
T 3 2FFFB 0 5
R 9 00000000 1 6
W 1 12345678 1 6
